/* verilog.f */
+incdir+verilog
verilog/sample_pkg.sv
verilog/apb_regs_pkg.sv
verilog/iq_stream_if.sv
verilog/iq_power.sv
verilog/frame_arg_max.sv
verilog/peak_apb_regs.sv
verilog/peak_search_top.sv
bench/peak_search_tb.sv

/* Makefile */
# Verilator build and run for the peak search testbench

TOP = peak_search_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f verilog.f --top-module $(TOP) --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/peak_search_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "peak_defines.svh"

module peak_search_tb;
   import sample_pkg::*;

   localparam int CLK_PERIOD    = 100;
   localparam int DRIVE_DELAY   = 10;
   localparam int TOTAL_SAMPLES = 8 * 16 + 3 * 16 + 3 + 10 + 1024 + 12 + 4;
   localparam int WATCHDOG_CYC  = TOTAL_SAMPLES * 20 + 2000;

   logic               clk;
   logic               i_rst_n;
   logic               i_s_valid;
   wire                o_s_ready;
   sample_t            i_s_i;
   sample_t            i_s_q;
   logic               i_psel;
   logic               i_penable;
   logic               i_pwrite;
   logic [`APB_AW-1:0] i_paddr;
   logic [31:0]        i_pwdata;
   wire  [31:0]        o_prdata;
   wire                o_pready;
   wire                o_pslverr;
   wire                o_irq;

   sample_t     stim_i[$];
   sample_t     stim_q[$];
   sample_t     ref_i[$];
   sample_t     ref_q[$];
   int          model_count;
   int          errors;
   int          err_mark;
   int          tests_run;
   int          tests_failed;
   logic [31:0] rd_power;
   logic [31:0] rd_index;
   bit          rst_done;

   peak_search_top dut0 (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ************************************************************
   // reference model

   function automatic void ref_peak(input int len, output power_t pw,
                                    output index_t ix, output count_t cnt);
      int a;
      int b;
      int p;
      int best;
      best = -1;
      ix   = '0;
      for (int n = 0; n < len; n++) begin
         a = ref_i.pop_front();
         b = ref_q.pop_front();
         p = ((a * a) >> (`SAMPLE_W - 1)) + ((b * b) >> (`SAMPLE_W - 1));
         // strictly greater, first of equal peaks wins
         if (p > best) begin
            best = p;
            ix   = index_t'(n);
         end
      end
      model_count++;
      pw  = power_t'(best);
      cnt = count_t'(model_count);
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input bit cond, input string what);
      assert (cond) else begin
         $display("ERROR: %s", what);
         errors++;
      end
   endtask

   // ************************************************************
   // APB and stream helpers

   task automatic apb_access(input logic wr, input logic [`APB_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      @(posedge clk);
      #DRIVE_DELAY;
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = wr;
      i_paddr   = addr;
      i_pwdata  = wdata;
      @(posedge clk);
      #DRIVE_DELAY;
      i_penable = 1'b1;
      @(negedge clk);
      rdata = o_prdata;
      err   = o_pslverr;
      // no wait states, the access phase always completes at once
      check_val("pready", 32'(o_pready), 32'd1);
      @(posedge clk);
      #DRIVE_DELAY;
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
      logic [31:0] unused_rd;
      logic        unused_err;
      apb_access(1'b1, addr, data, unused_rd, unused_err);
   endtask

   task automatic push_sample(input sample_t si, input sample_t sq);
      stim_i.push_back(si);
      stim_q.push_back(sq);
      ref_i.push_back(si);
      ref_q.push_back(sq);
   endtask

   task automatic push_random(input int n);
      for (int k = 0; k < n; k++) begin
         push_sample(sample_t'($urandom()), sample_t'($urandom()));
      end
   endtask

   task automatic push_const(input int n, input sample_t si, input sample_t sq);
      for (int k = 0; k < n; k++) begin
         push_sample(si, sq);
      end
   endtask

   task automatic wait_done();
      logic [31:0] rd;
      logic        err;
      int          polls;
      polls = 0;
      rd    = '0;
      while (!rd[0] && polls < 5000) begin
         apb_access(1'b0, `REG_STATUS, '0, rd, err);
         polls++;
      end
      expect_true(rd[0], "done flag did not rise within the status poll limit");
   endtask

   task automatic clear_done();
      apb_write(`REG_STATUS, 32'h1);
   endtask

   task automatic check_result(input int len);
      power_t      ep;
      index_t      ei;
      count_t      ec;
      logic [31:0] rd;
      logic        err;
      ref_peak(len, ep, ei, ec);
      apb_access(1'b0, `REG_PEAK_POWER, '0, rd_power, err);
      check_val("peak_power", rd_power, 32'(ep));
      apb_access(1'b0, `REG_PEAK_INDEX, '0, rd_index, err);
      check_val("peak_index", rd_index, 32'(ei));
      apb_access(1'b0, `REG_FRAME_COUNT, '0, rd, err);
      check_val("frame_count", rd, 32'(ec));
   endtask

   task automatic wait_stall(input int max_cycles, output bit seen);
      seen = 1'b0;
      for (int n = 0; n < max_cycles && !seen; n++) begin
         @(negedge clk);
         seen = !o_s_ready;
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((stim_i.size() != 0 || i_s_valid) && n < 1000) begin
         @(posedge clk);
         n++;
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_mark);
         tests_failed++;
      end
      err_mark = errors;
   endtask

   // ************************************************************
   // sample driver, random gaps between samples

   initial begin : drive_stream
      int gap;
      bit rdy;
      wait (rst_done);
      forever begin
         if (stim_i.size() == 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
         end else begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
               @(posedge clk);
               #DRIVE_DELAY;
            end
            i_s_i     = stim_i.pop_front();
            i_s_q     = stim_q.pop_front();
            i_s_valid = 1'b1;
            do begin
               @(negedge clk);
               rdy = o_s_ready;
               @(posedge clk);
               #DRIVE_DELAY;
            end while (!rdy);
            i_s_valid = 1'b0;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYC);
      $display("Verification failed");
      $finish;
   end

   initial begin : run_tests
      logic [31:0] rd;
      logic        err;
      bit          seen;
      clk       = 1'b0;
      i_rst_n   = 1'b0;
      i_s_valid = 1'b0;
      i_s_i     = '0;
      i_s_q     = '0;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      void'($urandom(32'hcd16_cbdb));
      repeat (8) @(posedge clk);
      #DRIVE_DELAY;
      i_rst_n  = 1'b1;
      rst_done = 1'b1;
      apb_write(`REG_FRAME_LEN, 32'd16);
      apb_write(`REG_CTRL, 32'h1);

      push_random(8 * 16);
      for (int f = 0; f < 8; f++) begin
         wait_done();
         check_result(16);
         clear_done();
      end
      end_test("random frames");

      // equal peaks at 3 and 10, then full-scale and zero frames
      for (int k = 0; k < 16; k++) begin
         if (k == 3) begin
            push_sample(12'sd1000, -12'sd500);
         end else if (k == 10) begin
            push_sample(-12'sd1000, 12'sd500);
         end else begin
            push_sample(sample_t'($urandom_range(0, 63)), sample_t'($urandom_range(0, 63)));
         end
      end
      push_const(16, 12'sh800, 12'sh800);
      push_const(16, '0, '0);
      wait_done();
      check_result(16);
      check_val("peak_index", rd_index, 32'd3);
      clear_done();
      wait_done();
      check_result(16);
      check_val("peak_power", rd_power, 32'd4096);
      clear_done();
      wait_done();
      check_result(16);
      check_val("peak_power", rd_power, 32'd0);
      check_val("peak_index", rd_index, 32'd0);
      clear_done();
      end_test("ties and extremes");

      apb_write(`REG_FRAME_LEN, 32'd1);
      push_random(3);
      for (int f = 0; f < 3; f++) begin
         wait_done();
         check_result(1);
         clear_done();
      end
      apb_write(`REG_FRAME_LEN, 32'd5);
      push_random(10);
      for (int f = 0; f < 2; f++) begin
         wait_done();
         check_result(5);
         clear_done();
      end
      apb_write(`REG_FRAME_LEN, 32'd0);
      apb_access(1'b0, `REG_FRAME_LEN, '0, rd, err);
      check_val("frame_len", rd, 32'd1024);
      push_random(1024);
      wait_done();
      check_result(1024);
      clear_done();
      end_test("frame length");

      // second result must wait while done stays set
      apb_write(`REG_FRAME_LEN, 32'd4);
      push_random(12);
      wait_done();
      wait_stall(200, seen);
      expect_true(seen, "o_s_ready did not fall while a result was pending");
      for (int f = 0; f < 3; f++) begin
         if (f != 0) begin
            wait_done();
         end
         check_result(4);
         clear_done();
      end
      end_test("back-pressure");

      apb_access(1'b0, 8'h18, '0, rd, err);
      check_val("pslverr", 32'(err), 32'd1);
      apb_access(1'b0, `REG_CTRL, '0, rd, err);
      check_val("pslverr", 32'(err), 32'd0);
      push_random(2);
      wait_drained();
      apb_access(1'b0, `REG_STATUS, '0, rd, err);
      check_val("status", rd, 32'h2);
      apb_write(`REG_CTRL, 32'h0);
      push_random(2);
      wait_stall(50, seen);
      expect_true(seen, "o_s_ready stayed high with enable cleared");
      apb_access(1'b0, `REG_STATUS, '0, rd, err);
      check_val("status", rd, 32'h2);
      apb_write(`REG_CTRL, 32'h1);
      wait_done();
      repeat (3) @(negedge clk);
      check_val("o_irq", 32'(o_irq), 32'd0);
      apb_write(`REG_CTRL, 32'h3);
      repeat (3) @(negedge clk);
      check_val("o_irq", 32'(o_irq), 32'd1);
      check_result(4);
      clear_done();
      repeat (3) @(negedge clk);
      check_val("o_irq", 32'(o_irq), 32'd0);
      // idle with the frame finished and done cleared
      apb_access(1'b0, `REG_STATUS, '0, rd, err);
      check_val("status", rd, 32'h0);
      end_test("register access");

      $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/peak_search_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "peak_defines.svh"

module peak_search_top (
   input  wire                      clk,
   input  wire                      i_rst_n,
   input  wire                      i_s_valid,
   output wire                      o_s_ready,
   input  wire sample_pkg::sample_t i_s_i,
   input  wire sample_pkg::sample_t i_s_q,
   input  wire                      i_psel,
   input  wire                      i_penable,
   input  wire                      i_pwrite,
   input  wire logic [`APB_AW-1:0]  i_paddr,
   input  wire apb_regs_pkg::apb_data_t i_pwdata,
   output wire apb_regs_pkg::apb_data_t o_prdata,
   output wire                      o_pready,
   output wire                      o_pslverr,
   output wire                      o_irq
);
   import sample_pkg::*;

   logic       enable;
   frame_len_t frame_len;
   logic       res_valid;
   power_t     peak_power;
   index_t     peak_index;
   count_t     frame_count;
   logic       res_busy;
   logic       busy;

   // power stage to frame search
   iq_stream_if pwr_s ();

   iq_power power0 (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_valid (i_s_valid),
      .o_ready (o_s_ready),
      .i_i     (i_s_i),
      .i_q     (i_s_q),
      .o_pwr   (pwr_s.source)
   );

   frame_arg_max search0 (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_enable      (enable),
      .i_frame_len   (frame_len),
      .i_pwr         (pwr_s.sink),
      .o_res_valid   (res_valid),
      .o_peak_power  (peak_power),
      .o_peak_index  (peak_index),
      .o_frame_count (frame_count),
      .i_res_busy    (res_busy),
      .o_busy        (busy)
   );

   peak_apb_regs regs0 (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .o_prdata      (o_prdata),
      .o_pready      (o_pready),
      .o_pslverr     (o_pslverr),
      .o_enable      (enable),
      .o_frame_len   (frame_len),
      .i_res_valid   (res_valid),
      .i_peak_power  (peak_power),
      .i_peak_index  (peak_index),
      .i_frame_count (frame_count),
      .i_busy        (busy),
      .o_res_busy    (res_busy),
      .o_irq         (o_irq)
   );

endmodule

`default_nettype wire

/* verilog/peak_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "peak_defines.svh"

module peak_apb_regs (
   input  wire                      clk,
   input  wire                      i_rst_n,
   input  wire                      i_psel,
   input  wire                      i_penable,
   input  wire                      i_pwrite,
   input  wire logic [`APB_AW-1:0]  i_paddr,
   input  wire apb_regs_pkg::apb_data_t i_pwdata,
   output apb_regs_pkg::apb_data_t  o_prdata,
   output logic                     o_pready,
   output logic                     o_pslverr,
   output logic                     o_enable,
   output sample_pkg::frame_len_t   o_frame_len,
   input  wire                      i_res_valid,
   input  wire sample_pkg::power_t  i_peak_power,
   input  wire sample_pkg::index_t  i_peak_index,
   input  wire sample_pkg::count_t  i_frame_count,
   input  wire                      i_busy,
   output logic                     o_res_busy,
   output logic                     o_irq
);
   import sample_pkg::*;
   import apb_regs_pkg::*;

   ctrl_t      ctrl_q;
   frame_len_t frame_len_q;
   logic       done_q;
   logic       irq_q;
   power_t     peak_power_q;
   index_t     peak_index_q;
   count_t     frame_count_q;
   reg_addr_e  addr;
   logic       access;
   logic       mapped;
   logic       wr_en;
   apb_data_t  rdata;

   // 0 and anything past the limit mean a full-size frame
   function automatic frame_len_t clamp_len(input apb_data_t wdata);
      if (wdata == '0 || wdata > `MAX_FRAME) begin
         return frame_len_t'(`MAX_FRAME);
      end
      return frame_len_t'(wdata);
   endfunction

   assign addr   = reg_addr_e'(i_paddr);
   assign access = i_psel & i_penable;
   assign wr_en  = access & i_pwrite & mapped;

   // ************************************************************
   // read mux and address decode

   always_comb begin
      mapped = 1'b1;
      rdata  = '0;
      case (addr)
         ADDR_CTRL:        rdata = apb_data_t'(ctrl_q);
         ADDR_FRAME_LEN:   rdata = apb_data_t'(frame_len_q);
         ADDR_STATUS: begin
            rdata[STATUS_DONE_BIT] = done_q;
            rdata[STATUS_BUSY_BIT] = i_busy;
         end
         ADDR_PEAK_POWER:  rdata = apb_data_t'(peak_power_q);
         ADDR_PEAK_INDEX:  rdata = apb_data_t'(peak_index_q);
         ADDR_FRAME_COUNT: rdata = apb_data_t'(frame_count_q);
         default:          mapped = 1'b0;
      endcase
   end

   assign o_prdata  = rdata;
   assign o_pready  = 1'b1;
   assign o_pslverr = access & ~mapped;

   // ************************************************************
   // control, status and interrupt

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ctrl_q        <= '0;
         frame_len_q   <= frame_len_t'(`MAX_FRAME);
         done_q        <= 1'b0;
         irq_q         <= 1'b0;
         frame_count_q <= '0;
      end else begin
         irq_q <= done_q & ctrl_q[CTRL_IRQ_EN_BIT];
         if (wr_en && addr == ADDR_CTRL) begin
            ctrl_q <= ctrl_t'(i_pwdata);
         end
         if (wr_en && addr == ADDR_FRAME_LEN) begin
            frame_len_q <= clamp_len(i_pwdata);
         end
         if (i_res_valid) begin
            done_q        <= 1'b1;
            frame_count_q <= i_frame_count;
         end else if (wr_en && addr == ADDR_STATUS && i_pwdata[STATUS_DONE_BIT]) begin
            done_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_res_valid) begin
         peak_power_q <= i_peak_power;
         peak_index_q <= i_peak_index;
      end
   end

   assign o_enable    = ctrl_q[CTRL_ENABLE_BIT];
   assign o_frame_len = frame_len_q;
   assign o_res_busy  = done_q;
   assign o_irq       = irq_q;

   // error response only follows a proper setup phase
   a_slverr_access: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_pslverr |-> i_penable && $past(i_psel && !i_penable)
   );

endmodule

`default_nettype wire

/* verilog/frame_arg_max.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_arg_max (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  wire                     i_enable,
   input  wire sample_pkg::frame_len_t i_frame_len,
   iq_stream_if.sink               i_pwr,
   output logic                    o_res_valid,
   output sample_pkg::power_t      o_peak_power,
   output sample_pkg::index_t      o_peak_index,
   output sample_pkg::count_t      o_frame_count,
   input  wire                     i_res_busy,
   output logic                    o_busy
);
   import sample_pkg::*;

   typedef enum logic {
      ST_COLLECT,
      ST_HOLD
   } state_e;

   state_e     state_q;
   index_t     cnt_q;
   frame_len_t len_q;
   frame_len_t cur_len;
   power_t     max_q;
   index_t     idx_q;
   power_t     max_d;
   index_t     idx_d;
   logic       take;
   logic       last;

   assign i_pwr.ready = i_enable && (state_q == ST_COLLECT);
   assign take        = i_pwr.valid && i_pwr.ready;

   // first sample of a frame sees the live length, later ones the latched copy
   assign cur_len = (cnt_q == '0) ? i_frame_len : len_q;
   assign last    = ({1'b0, cnt_q} == cur_len - 1'b1);

   assign o_busy = (cnt_q != '0) || (state_q == ST_HOLD);

   // strictly greater keeps the earliest index on a tie
   always_comb begin
      max_d = max_q;
      idx_d = idx_q;
      if (cnt_q == '0 || i_pwr.power > max_q) begin
         max_d = i_pwr.power;
         idx_d = cnt_q;
      end
   end

   // ************************************************************
   // frame FSM

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q       <= ST_COLLECT;
         cnt_q         <= '0;
         o_res_valid   <= 1'b0;
         o_frame_count <= '0;
      end else begin
         o_res_valid <= 1'b0;
         case (state_q)
            ST_COLLECT: begin
               if (take) begin
                  if (last) begin
                     cnt_q         <= '0;
                     o_frame_count <= o_frame_count + 1'b1;
                     // previous result unread or still in flight, park this one
                     if (i_res_busy || o_res_valid) begin
                        state_q <= ST_HOLD;
                     end else begin
                        o_res_valid <= 1'b1;
                     end
                  end else begin
                     cnt_q <= cnt_q + 1'b1;
                  end
               end
            end
            ST_HOLD: begin
               if (!i_res_busy) begin
                  state_q     <= ST_COLLECT;
                  o_res_valid <= 1'b1;
               end
            end
            default: state_q <= ST_COLLECT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         max_q <= max_d;
         idx_q <= idx_d;
         if (cnt_q == '0) begin
            len_q <= i_frame_len;
         end
         if (last) begin
            o_peak_power <= max_d;
            o_peak_index <= idx_d;
         end
      end
   end

   // ************************************************************

   a_cnt_below_len: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      cnt_q != '0 |-> {1'b0, cnt_q} < len_q
   );

   // the register block must have released the previous result
   a_no_result_while_busy: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_res_valid |-> !i_res_busy
   );

endmodule

`default_nettype wire

/* verilog/iq_power.sv */
`timescale 1ns/1ns
`default_nettype none

`include "peak_defines.svh"

module iq_power (
   input  wire                 clk,
   input  wire                 i_rst_n,
   input  wire                 i_valid,
   output logic                o_ready,
   input  wire sample_pkg::sample_t i_i,
   input  wire sample_pkg::sample_t i_q,
   iq_stream_if.source         o_pwr
);
   import sample_pkg::*;

   localparam int SQ_W = 2 * `SAMPLE_W;

   logic signed [SQ_W-1:0] i_sq;
   logic signed [SQ_W-1:0] q_sq;
   power_t                 pwr_d;
   logic                   take;

   // squares are never negative, top bit of the product is unused
   assign i_sq = i_i * i_i;
   assign q_sq = i_q * i_q;

   assign pwr_d = power_t'(i_sq[SQ_W-2:`SAMPLE_W-1])
                + power_t'(q_sq[SQ_W-2:`SAMPLE_W-1]);

   // accept when the output slot is empty or being drained
   assign o_ready = o_pwr.ready | ~o_pwr.valid;
   assign take    = i_valid & o_ready;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_pwr.valid <= 1'b0;
      end else if (take) begin
         o_pwr.valid <= 1'b1;
      end else if (o_pwr.ready) begin
         o_pwr.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         o_pwr.i     <= i_i;
         o_pwr.q     <= i_q;
         o_pwr.power <= pwr_d;
      end
   end

   // ************************************************************
   // stalled output holds its item until the sink takes it

   a_stall_stable: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_pwr.valid && !o_pwr.ready |=> o_pwr.valid && $stable(o_pwr.power)
   );

endmodule

`default_nettype wire

/* verilog/iq_stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface iq_stream_if;
   import sample_pkg::*;

   logic    valid;
   logic    ready;
   sample_t i;
   sample_t q;
   power_t  power;

   // transfer on a clock edge with valid and ready both high
   modport source (
      output valid,
      output i,
      output q,
      output power,
      input  ready
   );

   modport sink (
      input  valid,
      input  i,
      input  q,
      input  power,
      output ready
   );

endinterface

`default_nettype wire

/* verilog/apb_regs_pkg.sv */
`default_nettype none

`include "peak_defines.svh"

package apb_regs_pkg;

   typedef logic [31:0] apb_data_t;

   // bit 0 enable, bit 1 irq_en
   typedef logic [1:0] ctrl_t;

   typedef enum logic [`APB_AW-1:0] {
      ADDR_CTRL        = `REG_CTRL,
      ADDR_FRAME_LEN   = `REG_FRAME_LEN,
      ADDR_STATUS      = `REG_STATUS,
      ADDR_PEAK_POWER  = `REG_PEAK_POWER,
      ADDR_PEAK_INDEX  = `REG_PEAK_INDEX,
      ADDR_FRAME_COUNT = `REG_FRAME_COUNT
   } reg_addr_e;

   // CTRL fields
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_IRQ_EN_BIT = 1;

   // STATUS fields, done is write-1-to-clear
   localparam int STATUS_DONE_BIT = 0;
   localparam int STATUS_BUSY_BIT = 1;

endpackage

`default_nettype wire

/* verilog/sample_pkg.sv */
`default_nettype none

`include "peak_defines.svh"

package sample_pkg;

   // one signed I or Q component
   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   // scaled power, (i*i >> (SAMPLE_W-1)) + (q*q >> (SAMPLE_W-1))
   typedef logic [`POWER_W-1:0] power_t;

   // position of a sample inside its frame
   typedef logic [`INDEX_W-1:0] index_t;

   // completed frames, wraps
   typedef logic [`COUNT_W-1:0] count_t;

   // one bit wider than the index so MAX_FRAME itself fits
   typedef logic [$clog2(`MAX_FRAME):0] frame_len_t;

endpackage

`default_nettype wire

/* verilog/peak_defines.svh */
`ifndef PEAK_DEFINES_SVH
`define PEAK_DEFINES_SVH

// sample path widths
`define SAMPLE_W 12
`define POWER_W (`SAMPLE_W + 1)

// frame limits, index covers 0 .. MAX_FRAME-1
`define MAX_FRAME 1024
`define INDEX_W 10
`define COUNT_W 16

// APB register port
`define APB_AW 8

// register byte offsets
`define REG_CTRL 8'h00
`define REG_FRAME_LEN 8'h04
`define REG_STATUS 8'h08
`define REG_PEAK_POWER 8'h0C
`define REG_PEAK_INDEX 8'h10
`define REG_FRAME_COUNT 8'h14

`endif
